// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       ?= aes_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Everything OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/aes_model.svh ====
`ifndef AES_MODEL_SVH
`define AES_MODEL_SVH

// Byte i of a block sits at bits 127-8*i down to 120-8*i, column c row r at i = 4c+r

logic [7:0] sbox_tab [256];
logic [7:0] inv_sbox_tab [256];

function automatic logic [7:0] mul2(input logic [7:0] b);
	logic [7:0] r;
	r = {b[6:0], 1'b0};
	if (b[7])
		r = r ^ 8'h1b;
	return r;
endfunction

function automatic logic [7:0] gmul(input logic [7:0] a, input logic [7:0] b);
	logic [7:0] p;
	logic [7:0] x;
	logic [7:0] y;
	p = 8'h00;
	x = a;
	y = b;
	while (y != 8'h00) begin
		if (y[0])
			p = p ^ x;
		x = mul2(x);
		y = y >> 1;
	end
	return p;
endfunction

function automatic logic [7:0] rot8(input logic [7:0] b, input int n);
	logic [15:0] d;
	d = {b, b} << n;
	return d[15:8];
endfunction

// Walks the powers of 3 and their inverses through the whole field
task automatic build_sbox_tables();
	logic [7:0] p;
	logic [7:0] q;
	logic [7:0] x;
	p = 8'h01;
	q = 8'h01;
	do begin
		p = p ^ mul2(p);
		q = q ^ (q << 1);
		q = q ^ (q << 2);
		q = q ^ (q << 4);
		if (q[7])
			q = q ^ 8'h09;
		x = q ^ rot8(q, 1) ^ rot8(q, 2) ^ rot8(q, 3) ^ rot8(q, 4) ^ 8'h63;
		sbox_tab[p] = x;
		inv_sbox_tab[x] = p;
	end while (p != 8'h01);
	sbox_tab[0] = 8'h63;
	inv_sbox_tab[8'h63] = 8'h00;
endtask

function automatic logic [127:0] sub_bytes(input logic [127:0] s, input bit inverse);
	logic [127:0] o;
	for (int i = 0; i < 16; i++) begin
		if (inverse)
			o[127 - 8*i -: 8] = inv_sbox_tab[s[127 - 8*i -: 8]];
		else
			o[127 - 8*i -: 8] = sbox_tab[s[127 - 8*i -: 8]];
	end
	return o;
endfunction

function automatic logic [127:0] shift_rows(input logic [127:0] s, input bit inverse);
	logic [127:0] o;
	int src;
	for (int c = 0; c < 4; c++) begin
		for (int r = 0; r < 4; r++) begin
			src = inverse ? 4 * ((c - r + 4) % 4) + r : 4 * ((c + r) % 4) + r;
			o[127 - 8*(4*c + r) -: 8] = s[127 - 8*src -: 8];
		end
	end
	return o;
endfunction

function automatic logic [127:0] mix_columns(input logic [127:0] s, input bit inverse);
	logic [7:0] coef [4];
	logic [7:0] b;
	logic [127:0] o;
	coef[0] = inverse ? 8'h0e : 8'h02;
	coef[1] = inverse ? 8'h0b : 8'h03;
	coef[2] = inverse ? 8'h0d : 8'h01;
	coef[3] = inverse ? 8'h09 : 8'h01;
	for (int c = 0; c < 4; c++) begin
		for (int r = 0; r < 4; r++) begin
			b = 8'h00;
			for (int k = 0; k < 4; k++)
				b = b ^ gmul(coef[(k - r + 4) % 4], s[127 - 8*(4*c + k) -: 8]);
			o[127 - 8*(4*c + r) -: 8] = b;
		end
	end
	return o;
endfunction

function automatic logic [0:`AES_ROUNDS][127:0] expand_key(input logic [127:0] key);
	logic [31:0] w [4 * (`AES_ROUNDS + 1)];
	logic [31:0] t;
	logic [7:0] rc;
	logic [0:`AES_ROUNDS][127:0] rk;
	rc = 8'h01;
	for (int i = 0; i < 4; i++)
		w[i] = key[127 - 32*i -: 32];
	for (int i = 4; i < 4 * (`AES_ROUNDS + 1); i++) begin
		t = w[i - 1];
		if (i % 4 == 0) begin
			t = {t[23:0], t[31:24]};
			t = {sbox_tab[t[31:24]], sbox_tab[t[23:16]], sbox_tab[t[15:8]], sbox_tab[t[7:0]]};
			t[31:24] = t[31:24] ^ rc;
			rc = mul2(rc);
		end
		w[i] = w[i - 4] ^ t;
	end
	for (int r = 0; r <= `AES_ROUNDS; r++)
		rk[r] = {w[4*r], w[4*r + 1], w[4*r + 2], w[4*r + 3]};
	return rk;
endfunction

function automatic logic [127:0] encrypt_block(input logic [127:0] key, input logic [127:0] pt);
	logic [0:`AES_ROUNDS][127:0] rk;
	logic [127:0] s;
	rk = expand_key(key);
	s = pt ^ rk[0];
	for (int r = 1; r <= `AES_ROUNDS; r++) begin
		s = shift_rows(sub_bytes(s, 1'b0), 1'b0);
		if (r != `AES_ROUNDS)
			s = mix_columns(s, 1'b0);
		s = s ^ rk[r];
	end
	return s;
endfunction

function automatic logic [127:0] decrypt_block(input logic [127:0] key, input logic [127:0] ct);
	logic [0:`AES_ROUNDS][127:0] rk;
	logic [127:0] s;
	rk = expand_key(key);
	s = ct ^ rk[`AES_ROUNDS];
	for (int r = `AES_ROUNDS - 1; r >= 0; r--) begin
		s = sub_bytes(shift_rows(s, 1'b1), 1'b1);
		s = s ^ rk[r];
		if (r != 0)
			s = mix_columns(s, 1'b1);
	end
	return s;
endfunction

`endif

// ==== bench/aes_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aes_config.svh"

module aes_tb;

	localparam int TIMEOUT = 50;

	logic                       clk;
	logic                       rst_n;
	logic                       en;
	logic                       cipher_mode;
	logic                       decipher_mode;
	logic                       key_exp_mode;
	logic [`AES_BLOCK_BITS-1:0] aes_key;
	logic [`AES_BLOCK_BITS-1:0] aes_in_blk;
	logic [`AES_BLOCK_BITS-1:0] aes_out_blk;
	logic                       aes_op_in_progress;
	logic                       en_o;

	int                         errors;
	int                         checks;
	logic [31:0]                lcg_state;
	logic [`AES_BLOCK_BITS-1:0] ref_key;
	logic [`AES_BLOCK_BITS-1:0] last_out;

	`include "aes_model.svh"

	aes_top dut (
		.clk                (clk),
		.rst_n              (rst_n),
		.en                 (en),
		.cipher_mode        (cipher_mode),
		.decipher_mode      (decipher_mode),
		.key_exp_mode       (key_exp_mode),
		.aes_key            (aes_key),
		.aes_in_blk         (aes_in_blk),
		.aes_out_blk        (aes_out_blk),
		.aes_op_in_progress (aes_op_in_progress),
		.en_o               (en_o)
	);

	always #20 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic random_block(output logic [127:0] b);
		for (int i = 0; i < 4; i++) begin
			lcg_state = lcg_next(lcg_state);
			b = {b[95:0], lcg_state};
		end
	endtask

	task automatic check_value(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("mismatch at %0t: %s expected %h, actual %h", $time, name, expected, actual);
		end
	endtask

	task automatic end_run();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	endtask

	// Caller has set mode and data; en is high for one cycle
	task automatic start_and_wait(input string op_name, input int latency);
		int  cycles;
		bit  seen;
		en = 1'b1;
		@(negedge clk);
		check_value("aes_op_in_progress", 1'b0, aes_op_in_progress);
		check_value("en_o", 1'b0, en_o);
		@(posedge clk);
		#2;
		en = 1'b0;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
			if (en_o === 1'b1)
				seen = 1'b1;
			else
				check_value("aes_op_in_progress", 1'b1, aes_op_in_progress);
		end
		if (!seen) begin
			$display("no en_o within %0d cycles after starting %s", TIMEOUT, op_name);
			errors++;
			end_run();
		end
		check_value({op_name, " latency"}, latency, cycles);
		@(posedge clk);
		#2;
		check_value("en_o", 1'b0, en_o);
		check_value("aes_op_in_progress", 1'b0, aes_op_in_progress);
	endtask

	task automatic load_key(input logic [127:0] key);
		ref_key = key;
		aes_key = key;
		key_exp_mode = 1'b1;
		cipher_mode = 1'b0;
		decipher_mode = 1'b0;
		start_and_wait("key expansion", `AES_ROUNDS);
	endtask

	task automatic encrypt_op(input logic [127:0] blk, output logic [127:0] result);
		aes_in_blk = blk;
		key_exp_mode = 1'b0;
		cipher_mode = 1'b1;
		decipher_mode = 1'b0;
		start_and_wait("encryption", `AES_ROUNDS + 1);
		result = last_out;
	endtask

	task automatic decrypt_op(input logic [127:0] blk, output logic [127:0] result);
		aes_in_blk = blk;
		key_exp_mode = 1'b0;
		cipher_mode = 1'b0;
		decipher_mode = 1'b1;
		start_and_wait("decryption", `AES_ROUNDS + 1);
		result = last_out;
	endtask

	// Output checked against the model whenever an operation ends
	always @(negedge clk) begin : compare
		logic [127:0] expected;
		if (rst_n === 1'b1 && en_o === 1'b1) begin
			if (cipher_mode)
				expected = encrypt_block(ref_key, aes_in_blk);
			else if (decipher_mode)
				expected = decrypt_block(ref_key, aes_in_blk);
			else
				expected = '0;
			check_value("aes_out_blk", expected, aes_out_blk);
			last_out = aes_out_blk;
		end
	end

	initial begin : stimulus
		logic [127:0] key;
		logic [127:0] blk;
		logic [127:0] ct;
		logic [127:0] pt;
		logic [127:0] old_ct;
		errors = 0;
		checks = 0;
		lcg_state = 32'd97;
		clk = 1'b0;
		rst_n = 1'b0;
		en = 1'b0;
		cipher_mode = 1'b0;
		decipher_mode = 1'b0;
		key_exp_mode = 1'b0;
		aes_key = '0;
		aes_in_blk = '0;
		ref_key = '0;
		last_out = '0;
		build_sbox_tables();
		repeat (2) @(posedge clk);
		#2;
		rst_n = 1'b1;

		// Idle after reset
		for (int i = 0; i < 3; i++) begin
			@(negedge clk);
			check_value("en_o", 1'b0, en_o);
			check_value("aes_op_in_progress", 1'b0, aes_op_in_progress);
		end
		@(posedge clk);
		#2;

		// FIPS-197 example vector
		key = 128'h000102030405060708090a0b0c0d0e0f;
		blk = 128'h00112233445566778899aabbccddeeff;
		load_key(key);
		encrypt_op(blk, ct);
		check_value("ciphertext", 128'h69c4e0d86a7b0430d8cdb78070b4c55a, ct);
		decrypt_op(ct, pt);
		check_value("plaintext", blk, pt);

		for (int k = 0; k < 20; k++) begin
			random_block(key);
			load_key(key);
			for (int b = 0; b < 3; b++) begin
				random_block(blk);
				encrypt_op(blk, ct);
				decrypt_op(ct, pt);
				check_value("round trip plaintext", blk, pt);
			end
		end

		// New key must replace every stored round key
		random_block(blk);
		encrypt_op(blk, old_ct);
		random_block(key);
		load_key(key);
		encrypt_op(blk, ct);
		check_value("result equal to old key result", 1'b0, ct === old_ct);

		end_run();
	end

endmodule

`default_nettype wire

// ==== logic/aes_config.svh ====
`ifndef AES_CONFIG_SVH
`define AES_CONFIG_SVH

// Block and round key width
`define AES_BLOCK_BITS 128

// AES-128 round count
`define AES_ROUNDS 10

// Key memory holds rounds 0 to AES_ROUNDS
`define AES_RKEY_ADDR_BITS 4

`endif

// ==== logic/aes_pkg.sv ====
`default_nettype none

`include "aes_config.svh"

package aes_pkg;

	// col[c][r] is the byte at row r, column c; col[0][0] is the top byte of word
	typedef union packed {
		logic [`AES_BLOCK_BITS-1:0] word;
		logic [0:3][0:3][7:0]       col;
	} aes_state_t;

	// Round index, doubles as key memory address
	typedef logic [`AES_RKEY_ADDR_BITS-1:0] round_no_t;

	// Multiply by x in GF(2^8) modulo x^8 + x^4 + x^3 + x + 1
	function automatic logic [7:0] gf_xtime(input logic [7:0] b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

endpackage

`default_nettype wire

// ==== logic/aes_sbox.sv ====
`timescale 1ns/1ps
`default_nettype none

module aes_sbox #(
	parameter bit INVERSE = 1'b0
) (
	input  wire [7:0] in_byte,
	output logic [7:0] out_byte
);
	import aes_pkg::*;

	logic [7:0] pre;
	logic [7:0] x2;
	logic [7:0] x3;
	logic [7:0] x12;
	logic [7:0] x15;
	logic [7:0] x240;
	logic [7:0] x252;
	logic [7:0] inv;

	function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
		logic [7:0] p;
		logic [7:0] t;
		p = 8'h00;
		t = a;
		for (int i = 0; i < 8; i++) begin
			if (b[i])
				p = p ^ t;
			t = gf_xtime(t);
		end
		return p;
	endfunction

	function automatic logic [7:0] gf_sq(input logic [7:0] a);
		return gf_mul(a, a);
	endfunction

	function automatic logic [7:0] rotl(input logic [7:0] b, input int n);
		return (b << n) | (b >> (8 - n));
	endfunction

	// Inverse affine comes before the field inversion
	assign pre = INVERSE ? (rotl(in_byte, 1) ^ rotl(in_byte, 3) ^ rotl(in_byte, 6) ^ 8'h05)
	                     : in_byte;

	// Inverse as a^254; zero maps to zero on its own
	assign x2   = gf_sq(pre);
	assign x3   = gf_mul(x2, pre);
	assign x12  = gf_sq(gf_sq(x3));
	assign x15  = gf_mul(x12, x3);
	assign x240 = gf_sq(gf_sq(gf_sq(gf_sq(x15))));
	assign x252 = gf_mul(x240, x12);
	assign inv  = gf_mul(x252, x2);

	// Forward affine after inversion
	assign out_byte = INVERSE ? inv
	                          : (inv ^ rotl(inv, 1) ^ rotl(inv, 2) ^ rotl(inv, 3) ^
	                             rotl(inv, 4) ^ 8'h63);

endmodule

`default_nettype wire

// ==== logic/aes_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aes_config.svh"

module aes_top (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire                         en,
	input  wire                         cipher_mode,
	input  wire                         decipher_mode,
	input  wire                         key_exp_mode,
	input  wire [`AES_BLOCK_BITS-1:0]   aes_key,
	input  wire [`AES_BLOCK_BITS-1:0]   aes_in_blk,
	output logic [`AES_BLOCK_BITS-1:0]  aes_out_blk,
	output logic                        aes_op_in_progress,
	output logic                        en_o
);
	import aes_pkg::*;

	logic                       en_key_exp;
	logic                       en_cipher;
	logic                       en_decipher;
	logic [`AES_BLOCK_BITS-1:0] round_key_in;
	logic [`AES_BLOCK_BITS-1:0] round_key_out;
	logic [`AES_BLOCK_BITS-1:0] enc_blk;
	logic [`AES_BLOCK_BITS-1:0] dec_blk;
	round_no_t                  round_key_addr;
	round_no_t                  enc_round_no;
	round_no_t                  dec_round_no;
	round_no_t                  ram_addr;
	logic                       w_e;
	logic                       done_key_exp;
	logic                       done_cipher;
	logic                       done_decipher;

	assign en_key_exp  = en && key_exp_mode;
	assign en_cipher   = en && cipher_mode;
	assign en_decipher = en && decipher_mode;

	assign ram_addr = key_exp_mode  ? round_key_addr :
	                  cipher_mode   ? enc_round_no :
	                  decipher_mode ? dec_round_no : '0;

	key_ram u_key_ram (
		.clk    (clk),
		.addr   (ram_addr),
		.i_data (round_key_in),
		.w_e    (w_e),
		.o_data (round_key_out)
	);

	key_expander u_key_expander (
		.clk            (clk),
		.rst_n          (rst_n),
		.en             (en_key_exp),
		.key            (aes_key),
		.round_key      (round_key_in),
		.round_key_addr (round_key_addr),
		.w_e            (w_e),
		.done           (done_key_exp)
	);

	cipher_core u_cipher (
		.clk        (clk),
		.rst_n      (rst_n),
		.en         (en_cipher),
		.plaintext  (aes_in_blk),
		.round_key  (round_key_out),
		.round_no   (enc_round_no),
		.ciphertext (enc_blk),
		.done       (done_cipher)
	);

	decipher_core u_decipher (
		.clk        (clk),
		.rst_n      (rst_n),
		.en         (en_decipher),
		.ciphertext (aes_in_blk),
		.round_key  (round_key_out),
		.round_no   (dec_round_no),
		.plaintext  (dec_blk),
		.done       (done_decipher)
	);

	assign aes_out_blk = cipher_mode   ? enc_blk :
	                     decipher_mode ? dec_blk : '0;

	assign en_o = done_key_exp | done_cipher | done_decipher;

	always_ff @(posedge clk) begin
		if (!rst_n)
			aes_op_in_progress <= 1'b0;
		else if (en)
			aes_op_in_progress <= 1'b1;
		else if (en_o)
			aes_op_in_progress <= 1'b0;
	end

	a_one_mode: assert property (@(posedge clk) disable iff (!rst_n)
		en |-> $onehot({cipher_mode, decipher_mode, key_exp_mode}));

	// One operation at a time
	a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
		aes_op_in_progress |-> !en);

endmodule

`default_nettype wire

// ==== logic/cipher_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aes_config.svh"

module cipher_core (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire                         en,
	input  wire [`AES_BLOCK_BITS-1:0]   plaintext,
	input  wire [`AES_BLOCK_BITS-1:0]   round_key,
	output aes_pkg::round_no_t          round_no,
	output logic [`AES_BLOCK_BITS-1:0]  ciphertext,
	output logic                        done
);
	import aes_pkg::*;

	localparam round_no_t LAST = round_no_t'(`AES_ROUNDS);

	aes_state_t                 state;
	aes_state_t                 shifted;
	aes_state_t                 mixed;
	aes_state_t                 rnd_out;
	logic [`AES_BLOCK_BITS-1:0] result_q;
	round_no_t                  rnd;
	logic                       busy;
	logic [0:3][0:3][7:0]       sb_bytes;

	function automatic logic [0:3][7:0] mix_col(input logic [0:3][7:0] a);
		logic [0:3][7:0] m;
		for (int r = 0; r < 4; r++) begin
			m[r] = gf_xtime(a[r]) ^ gf_xtime(a[(r + 1) % 4]) ^ a[(r + 1) % 4] ^
			       a[(r + 2) % 4] ^ a[(r + 3) % 4];
		end
		return m;
	endfunction

	// SubBytes with ShiftRows folded into the byte selection
	genvar c;
	genvar r;
	generate
		for (c = 0; c < 4; c++) begin : g_col
			for (r = 0; r < 4; r++) begin : g_row
				aes_sbox #(.INVERSE(1'b0)) u_sbox (
					.in_byte  (state.col[(c + r) % 4][r]),
					.out_byte (sb_bytes[c][r])
				);
			end
		end
	endgenerate

	always_comb begin
		shifted.col = sb_bytes;
		for (int k = 0; k < 4; k++)
			mixed.col[k] = mix_col(shifted.col[k]);
		rnd_out.word = ((rnd == LAST) ? shifted.word : mixed.word) ^ round_key;
	end

	// rnd is the key applied this cycle; memory runs one address ahead
	assign round_no   = (busy && rnd != LAST) ? rnd + 1'b1 : '0;
	assign done       = busy && (rnd == LAST);
	assign ciphertext = done ? rnd_out.word : result_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			rnd  <= '0;
		end else if (en) begin
			busy <= 1'b1;
			rnd  <= '0;
		end else if (done) begin
			busy <= 1'b0;
			rnd  <= '0;
		end else if (busy) begin
			rnd <= rnd + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (en)
			state <= plaintext;
		else if (busy && rnd == '0)
			state.word <= state.word ^ round_key;
		else if (busy)
			state <= rnd_out;
		if (done)
			result_q <= rnd_out.word;
	end

	a_done_single: assert property (@(posedge clk) disable iff (!rst_n)
		done |=> !done);

endmodule

`default_nettype wire

// ==== logic/decipher_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aes_config.svh"

module decipher_core (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire                         en,
	input  wire [`AES_BLOCK_BITS-1:0]   ciphertext,
	input  wire [`AES_BLOCK_BITS-1:0]   round_key,
	output aes_pkg::round_no_t          round_no,
	output logic [`AES_BLOCK_BITS-1:0]  plaintext,
	output logic                        done
);
	import aes_pkg::*;

	localparam round_no_t LAST = round_no_t'(`AES_ROUNDS);

	aes_state_t                 state;
	aes_state_t                 added;
	aes_state_t                 rnd_out;
	logic [`AES_BLOCK_BITS-1:0] result_q;
	round_no_t                  rnd;
	logic                       busy;
	logic [0:3][0:3][7:0]       isb_bytes;

	function automatic logic [0:3][7:0] inv_mix_col(input logic [0:3][7:0] a);
		logic [0:3][7:0] m;
		logic [0:3][7:0] x2;
		logic [0:3][7:0] x4;
		logic [0:3][7:0] x8;
		for (int i = 0; i < 4; i++) begin
			x2[i] = gf_xtime(a[i]);
			x4[i] = gf_xtime(x2[i]);
			x8[i] = gf_xtime(x4[i]);
		end
		// Coefficients 0e, 0b, 0d, 09 along the row
		for (int r = 0; r < 4; r++) begin
			m[r] = (x8[r] ^ x4[r] ^ x2[r]) ^
			       (x8[(r + 1) % 4] ^ x2[(r + 1) % 4] ^ a[(r + 1) % 4]) ^
			       (x8[(r + 2) % 4] ^ x4[(r + 2) % 4] ^ a[(r + 2) % 4]) ^
			       (x8[(r + 3) % 4] ^ a[(r + 3) % 4]);
		end
		return m;
	endfunction

	// InvShiftRows moves row r right by r columns
	genvar c;
	genvar r;
	generate
		for (c = 0; c < 4; c++) begin : g_col
			for (r = 0; r < 4; r++) begin : g_row
				aes_sbox #(.INVERSE(1'b1)) u_sbox (
					.in_byte  (state.col[(c - r + 4) % 4][r]),
					.out_byte (isb_bytes[c][r])
				);
			end
		end
	endgenerate

	always_comb begin
		added.word = isb_bytes ^ round_key;
		rnd_out    = added;
		if (rnd != '0) begin
			for (int k = 0; k < 4; k++)
				rnd_out.col[k] = inv_mix_col(added.col[k]);
		end
	end

	// Idle address is the last round key, ready for the next start
	assign round_no  = (busy && rnd != '0) ? rnd - 1'b1 : LAST;
	assign done      = busy && (rnd == '0);
	assign plaintext = done ? rnd_out.word : result_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			rnd  <= LAST;
		end else if (en) begin
			busy <= 1'b1;
			rnd  <= LAST;
		end else if (done) begin
			busy <= 1'b0;
			rnd  <= LAST;
		end else if (busy) begin
			rnd <= rnd - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (en)
			state <= ciphertext;
		else if (busy && rnd == LAST)
			state.word <= state.word ^ round_key;
		else if (busy)
			state <= rnd_out;
		if (done)
			result_q <= rnd_out.word;
	end

endmodule

`default_nettype wire

// ==== logic/key_expander.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aes_config.svh"

module key_expander (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire                         en,
	input  wire [`AES_BLOCK_BITS-1:0]   key,
	output logic [`AES_BLOCK_BITS-1:0]  round_key,
	output aes_pkg::round_no_t          round_key_addr,
	output logic                        w_e,
	output logic                        done
);
	import aes_pkg::*;

	localparam round_no_t LAST = round_no_t'(`AES_ROUNDS);

	aes_state_t      cur_key;
	aes_state_t      next_key;
	logic [7:0]      rcon;
	round_no_t       cnt;
	logic            busy;
	logic [0:3][7:0] sub_word;

	// SubWord of RotWord of the last column
	genvar i;
	generate
		for (i = 0; i < 4; i++) begin : g_sub
			aes_sbox #(.INVERSE(1'b0)) u_sbox (
				.in_byte  (cur_key.col[3][(i + 1) % 4]),
				.out_byte (sub_word[i])
			);
		end
	endgenerate

	always_comb begin
		next_key.col[0] = cur_key.col[0] ^ sub_word ^ {rcon, 24'h000000};
		next_key.col[1] = cur_key.col[1] ^ next_key.col[0];
		next_key.col[2] = cur_key.col[2] ^ next_key.col[1];
		next_key.col[3] = cur_key.col[3] ^ next_key.col[2];
	end

	// Round key 0 goes straight from the input in the start cycle
	assign round_key      = busy ? next_key.word : key;
	assign round_key_addr = cnt;
	assign w_e            = en | busy;
	assign done           = busy && (cnt == LAST);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			cnt  <= '0;
		end else if (en) begin
			busy <= 1'b1;
			cnt  <= round_no_t'(1);
		end else if (done) begin
			busy <= 1'b0;
			cnt  <= '0;
		end else if (busy) begin
			cnt <= cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (en) begin
			cur_key <= key;
			rcon    <= 8'h01;
		end else if (busy) begin
			cur_key <= next_key;
			rcon    <= gf_xtime(rcon);
		end
	end

endmodule

`default_nettype wire

// ==== logic/key_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aes_config.svh"

module key_ram (
	input  wire                         clk,
	input  wire aes_pkg::round_no_t     addr,
	input  wire [`AES_BLOCK_BITS-1:0]   i_data,
	input  wire                         w_e,
	output logic [`AES_BLOCK_BITS-1:0]  o_data
);
	import aes_pkg::*;

	localparam int DEPTH = 1 << `AES_RKEY_ADDR_BITS;

	logic [`AES_BLOCK_BITS-1:0] mem [DEPTH];

	always_ff @(posedge clk) begin
		if (w_e)
			mem[addr] <= i_data;
		o_data <= mem[addr];
	end

	// Only rounds 0 to 10 are ever stored
	a_write_in_range: assert property (@(posedge clk)
		w_e |-> addr <= round_no_t'(`AES_ROUNDS));

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+logic
+incdir+bench
logic/aes_pkg.sv
logic/aes_sbox.sv
logic/key_ram.sv
logic/key_expander.sv
logic/cipher_core.sv
logic/decipher_core.sv
logic/aes_top.sv
bench/aes_tb.sv
